/* design/link_test_pkg.sv */
//--------------------------------------------------------------------------
// Shared widths, scrambler seed, stream beat and transmitter states.
// The beat width is fixed here; modules carry no width parameters.
//--------------------------------------------------------------------------

package link_test_pkg;

    // Width of one stream beat
    localparam int data_w = 32;

    // Width of frame size, pause size and counters
    localparam int cnt_w = 16;

    // Scrambler seed loaded on every reseed
    localparam logic [15:0] scr_init = 16'h55AA;

    // One beat on the stream without its valid
    typedef struct packed {
        logic [data_w-1:0] data;
        logic              sof;
        logic              eof;
        logic              seed;
    } mac_beat_t;

    // Transmitter FSM states
    typedef enum logic [1:0] {
        idle,
        tx_start,
        tx,
        pause
    } tx_state_t;

endpackage

/* design/sata_scrambler.sv */
//--------------------------------------------------------------------------
// SATA LFSR x16+x15+x13+x4+1, 32 steps per en. result belongs to the
// current state; with seed high it already shows the word of scr_init.
//--------------------------------------------------------------------------

module sata_scrambler (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             seed,
    input  logic                             en,
    output logic [link_test_pkg::data_w-1:0] result
);

    import link_test_pkg::*;

    logic [15:0] lfsr;
    logic [15:0] base;
    logic [15:0] lfsr_next;

    // Runs 32 LFSR steps, returns the next state above the output word
    function automatic logic [15+data_w:0] scr_run(input logic [15:0] s_in);
        logic [15:0]       s;
        logic [data_w-1:0] w;
        logic              fb;
        s = s_in;
        w = '0;
        for (int i = 0; i < data_w; i++) begin
            fb   = s[15] ^ s[14] ^ s[12] ^ s[3];
            w[i] = fb;
            s    = {s[14:0], fb};
        end
        return {s, w};
    endfunction

    // Seed bypass so a reseeded word is usable in the same cycle
    assign base = seed ? scr_init : lfsr;

    assign {lfsr_next, result} = scr_run(base);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= scr_init;
        end else if (en) begin
            lfsr <= lfsr_next;
        end else if (seed) begin
            lfsr <= scr_init;
        end
    end

endmodule

/* design/test_tx.sv */
//--------------------------------------------------------------------------
// Frame generator. pkt_size must be 2 or more, pause_size 1 or more.
// An inject_err seen while a beat is held lands on the following beat.
//--------------------------------------------------------------------------

module test_tx (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [link_test_pkg::cnt_w-1:0] pkt_size,
    input  logic [link_test_pkg::cnt_w-1:0] pause_size,
    input  logic                            inject_err,
    input  logic                            rdy,
    output logic                            valid,
    output link_test_pkg::mac_beat_t        beat
);

    import link_test_pkg::*;

    tx_state_t         state;
    logic [cnt_w-1:0]  cnt;
    logic [cnt_w-1:0]  pkt_cur;
    logic [cnt_w-1:0]  pause_cur;
    logic              seed_pulse;
    logic              first_frame;
    logic              sof_r;
    logic              eof_r;
    logic              seed_r;
    logic              flip;
    logic              err_pend;
    logic              accept;
    logic              last;
    logic              load_beat;
    logic [data_w-1:0] scr_word;

    sata_scrambler scrambler_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .seed   (seed_pulse),
        .en     (accept),
        .result (scr_word)
    );

    assign accept = valid & rdy;
    assign last   = (cnt == pkt_cur - 16'd1);

    // A new beat appears on the next edge
    assign load_beat = (state == tx_start && start && rdy) ||
                       (state == tx && rdy && !last);

    assign beat = '{data: scr_word ^ {{(data_w-1){1'b0}}, flip},
                    sof: sof_r, eof: eof_r, seed: seed_r};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= idle;
            cnt         <= '0;
            seed_pulse  <= 1'b0;
            first_frame <= 1'b0;
            valid       <= 1'b0;
            sof_r       <= 1'b0;
            eof_r       <= 1'b0;
            seed_r      <= 1'b0;
        end else begin
            seed_pulse <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        seed_pulse  <= 1'b1;
                        first_frame <= 1'b1;
                        state       <= tx_start;
                    end
                end
                tx_start: begin
                    pkt_cur   <= pkt_size;
                    pause_cur <= pause_size;
                    cnt       <= '0;
                    if (!start) begin
                        state <= idle;
                    end else if (rdy) begin
                        valid       <= 1'b1;
                        sof_r       <= 1'b1;
                        seed_r      <= first_frame;
                        first_frame <= 1'b0;
                        state       <= tx;
                    end
                end
                tx: begin
                    if (rdy) begin
                        sof_r  <= 1'b0;
                        seed_r <= 1'b0;
                        if (last) begin
                            valid <= 1'b0;
                            eof_r <= 1'b0;
                            cnt   <= '0;
                            state <= pause;
                        end else begin
                            eof_r <= (cnt == pkt_cur - 16'd2);
                            cnt   <= cnt + 16'd1;
                        end
                    end
                end
                pause: begin
                    if (cnt == pause_cur - 16'd1) begin
                        cnt   <= '0;
                        state <= start ? tx_start : idle;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Error flag is fixed per beat so a held beat never changes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flip     <= 1'b0;
            err_pend <= 1'b0;
        end else if (load_beat) begin
            flip     <= err_pend | inject_err;
            err_pend <= 1'b0;
        end else begin
            if (accept) begin
                flip <= 1'b0;
            end
            if (inject_err) begin
                err_pend <= 1'b1;
            end
        end
    end

endmodule

/* design/test_rx.sv */
//--------------------------------------------------------------------------
// Stream checker. Counters lag the accepted beat by one cycle and wrap.
// Only beats marked seed resynchronise the expected sequence.
//--------------------------------------------------------------------------

module test_rx (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            valid,
    input  logic                            rdy,
    input  link_test_pkg::mac_beat_t        beat,
    output logic [link_test_pkg::cnt_w-1:0] frame_cnt,
    output logic [link_test_pkg::cnt_w-1:0] err_cnt
);

    import link_test_pkg::*;

    logic              accept;
    logic              reseed;
    logic [data_w-1:0] expected;
    logic              hit_err;
    logic              hit_eof;

    assign accept = valid & rdy;
    assign reseed = accept & beat.seed;

    // Reseed bypass gives scr_init's first word for the seed beat itself
    sata_scrambler scrambler_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .seed   (reseed),
        .en     (accept),
        .result (expected)
    );

    // Compare stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_err <= 1'b0;
            hit_eof <= 1'b0;
        end else begin
            hit_err <= accept && (beat.data != expected);
            hit_eof <= accept && beat.eof;
        end
    end

    // Count stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
            err_cnt   <= '0;
        end else begin
            if (hit_eof) begin
                frame_cnt <= frame_cnt + 16'd1;
            end
            if (hit_err) begin
                err_cnt <= err_cnt + 16'd1;
            end
        end
    end

endmodule

/* design/link_test_top.sv */
//--------------------------------------------------------------------------
// Generator looped back into the checker. rdy comes from outside so the
// stream can be throttled; beat, valid and counters are all visible.
//--------------------------------------------------------------------------

module link_test_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic [link_test_pkg::cnt_w-1:0] pkt_size,
    input  logic [link_test_pkg::cnt_w-1:0] pause_size,
    input  logic                            inject_err,
    input  logic                            rdy,
    output logic                            valid,
    output link_test_pkg::mac_beat_t        beat,
    output logic [link_test_pkg::cnt_w-1:0] frame_cnt,
    output logic [link_test_pkg::cnt_w-1:0] err_cnt
);

    test_tx test_tx_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .pkt_size   (pkt_size),
        .pause_size (pause_size),
        .inject_err (inject_err),
        .rdy        (rdy),
        .valid      (valid),
        .beat       (beat)
    );

    // Checker sees exactly what leaves the generator
    test_rx test_rx_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (valid),
        .rdy       (rdy),
        .beat      (beat),
        .frame_cnt (frame_cnt),
        .err_cnt   (err_cnt)
    );

endmodule

/* tb/tb_monitor.sv */
//--------------------------------------------------------------------------
// Watches the DUT ports and checks frame structure, held beats and counters.
// Sampling is on the rising edge, before the DUT registers update.
//--------------------------------------------------------------------------

module tb_monitor (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            valid,
    input logic                            rdy,
    input link_test_pkg::mac_beat_t        beat,
    input logic [link_test_pkg::cnt_w-1:0] frame_cnt,
    input logic [link_test_pkg::cnt_w-1:0] err_cnt,
    input logic [link_test_pkg::cnt_w-1:0] pkt_size,
    input logic [link_test_pkg::cnt_w-1:0] pause_size
);

    timeunit 1ns;
    timeprecision 100ps;

    import link_test_pkg::*;

    string       test_name = "none";
    logic [31:0] exp_first = '0;
    int          test_errs = 0;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          beats = 0;
    int          seed_beats = 0;
    int          pause_left = 0;
    logic        in_frame = 1'b0;
    logic        prev_rst = 1'b0;
    logic        prev_valid = 1'b0;
    logic        prev_rdy = 1'b0;
    mac_beat_t   prev_beat;

    task automatic value_fail(input string what, input int exp, input int act);
        $display("FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
        test_errs++;
    endtask

    task automatic plain_fail(input string what);
        $display("Error in %s at %0t: %s", test_name, $time, what);
        test_errs++;
    endtask

    task automatic begin_test(input string name, input logic [31:0] first);
        test_name  = name;
        exp_first  = first;
        test_errs  = 0;
        beats      = 0;
        seed_beats = 0;
        pause_left = 0;
        in_frame   = 1'b0;
    endtask

    task automatic end_test(input int exp_frames, input int exp_errs, input int exp_seeds);
        if (int'(frame_cnt) != exp_frames) begin
            value_fail("frame_cnt", exp_frames, int'(frame_cnt));
        end
        if (int'(err_cnt) != exp_errs) begin
            value_fail("err_cnt", exp_errs, int'(err_cnt));
        end
        if (seed_beats != exp_seeds) begin
            value_fail("seed beats", exp_seeds, seed_beats);
        end
        if (in_frame) begin
            plain_fail("stream stopped inside a frame");
        end
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s with %0d errors", test_name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
    endtask

    task automatic report_counts();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errs);
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (!prev_rst && valid) begin
                plain_fail("valid is high right after reset");
            end
            if (prev_valid && !prev_rdy && (!valid || beat != prev_beat)) begin
                plain_fail("held beat changed while rdy was low");
            end
            if (pause_left > 0) begin
                if (valid) begin
                    plain_fail("valid is high during the pause");
                end
                pause_left--;
            end
            if (valid && rdy) begin
                if (beat.sof) begin
                    if (in_frame) begin
                        plain_fail("sof arrived inside a frame");
                    end
                    in_frame = 1'b1;
                    beats    = 1;
                    // Every restart must bring back the seed word
                    if (beat.seed) begin
                        seed_beats++;
                        if (beat.data != exp_first) begin
                            value_fail("first word", int'(exp_first), int'(beat.data));
                        end
                    end
                end else if (!in_frame) begin
                    plain_fail("beat accepted outside a frame");
                end else begin
                    beats++;
                end
                if (beat.eof) begin
                    if (beats != int'(pkt_size)) begin
                        value_fail("beats per frame", int'(pkt_size), beats);
                    end
                    in_frame   = 1'b0;
                    pause_left = int'(pause_size);
                end
            end
        end
        prev_rst   = rst_n;
        prev_valid = valid && rst_n;
        prev_rdy   = rdy;
        prev_beat  = beat;
    end

endmodule

/* tb/tb_link_test.sv */
//--------------------------------------------------------------------------
// Loopback testbench. Each test line runs one frame, returns to idle, then
// runs the remaining frames, so every test restarts the scramblers once.
//--------------------------------------------------------------------------

module tb_link_test;

    timeunit 1ns;
    timeprecision 100ps;

    import link_test_pkg::*;

    logic             clk;
    logic             rst_n;
    logic             start;
    logic [cnt_w-1:0] pkt_size;
    logic [cnt_w-1:0] pause_size;
    logic             inject_err;
    logic             rdy;
    logic             valid;
    mac_beat_t        beat;
    logic [cnt_w-1:0] frame_cnt;
    logic [cnt_w-1:0] err_cnt;

    integer seed = 99126;
    logic   rnd_rdy;

    string names[$];
    int    pkts[$];
    int    pauses[$];
    int    frames[$];
    int    injects[$];
    int    rnds[$];
    int    firsts[$];
    int    exp_frames[$];
    int    exp_errs[$];

    link_test_top link_test_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .pkt_size   (pkt_size),
        .pause_size (pause_size),
        .inject_err (inject_err),
        .rdy        (rdy),
        .valid      (valid),
        .beat       (beat),
        .frame_cnt  (frame_cnt),
        .err_cnt    (err_cnt)
    );

    tb_monitor tb_monitor_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid      (valid),
        .rdy        (rdy),
        .beat       (beat),
        .frame_cnt  (frame_cnt),
        .err_cnt    (err_cnt),
        .pkt_size   (pkt_size),
        .pause_size (pause_size)
    );

    always #2 clk = ~clk;

    // Back-pressure source
    always @(negedge clk) begin
        if (rnd_rdy) begin
            rdy = 1'($random(seed));
        end else begin
            rdy = 1'b1;
        end
    end

    task automatic load_stimulus(output bit ok);
        int    fd;
        int    n;
        string line;
        string name;
        int    f[8];
        ok = 1'b0;
        fd = $fopen("tb/link_test_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%s %d %d %d %d %d %h %d %d", name,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n == 9) begin
                    names.push_back(name);
                    pkts.push_back(f[0]);
                    pauses.push_back(f[1]);
                    frames.push_back(f[2]);
                    injects.push_back(f[3]);
                    rnds.push_back(f[4]);
                    firsts.push_back(f[5]);
                    exp_frames.push_back(f[6]);
                    exp_errs.push_back(f[7]);
                end
            end
            $fclose(fd);
            if (names.size() == 0) begin
                $display("The stimulus file holds no test lines");
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    // Raise start, drop it after the requested sof count, wait for idle
    task automatic run_burst(input int count);
        int sofs;
        int lows;
        sofs = 0;
        lows = 0;
        @(negedge clk);
        start = 1'b1;
        while (sofs < count) begin
            @(posedge clk);
            if (valid && rdy && beat.sof) begin
                sofs++;
            end
        end
        @(negedge clk);
        start = 1'b0;
        while (lows < int'(pause_size) + 3) begin
            @(posedge clk);
            if (valid) begin
                lows = 0;
            end else begin
                lows++;
            end
        end
    endtask

    // Pulses only on middle beats, so each corrupts a different beat
    task automatic send_injects(input int count);
        repeat (count) begin
            do begin
                @(negedge clk);
            end while (!(valid && !beat.sof && !beat.eof));
            inject_err = 1'b1;
            @(negedge clk);
            inject_err = 1'b0;
        end
    endtask

    initial begin
        int limit;
        bit stim_ok;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        pkt_size   = 16'd2;
        pause_size = 16'd1;
        inject_err = 1'b0;
        rdy        = 1'b0;
        rnd_rdy    = 1'b0;

        load_stimulus(stim_ok);

        if (!stim_ok) begin
            $display("Test FAILED");
            $finish;
        end else begin
            limit = 0;
            foreach (names[i]) begin
                limit += frames[i] * (pkts[i] * 4 + pauses[i] + 8) + 40;
            end

            // Watchdog
            fork
                begin
                    #(limit * 4);
                    $display("Timeout after %0d cycles, the DUT stopped making progress",
                             limit);
                    $display("Test FAILED");
                    $finish;
                end
            join_none

            foreach (names[i]) begin
                @(negedge clk);
                rst_n      = 1'b0;
                rnd_rdy    = (rnds[i] != 0);
                pkt_size   = cnt_w'(pkts[i]);
                pause_size = cnt_w'(pauses[i]);
                repeat (4) @(negedge clk);
                rst_n = 1'b1;
                tb_monitor_inst.begin_test(names[i], firsts[i]);
                fork
                    begin
                        run_burst(1);
                        run_burst(frames[i] - 1);
                    end
                    send_injects(injects[i]);
                join
                repeat (3) @(posedge clk);
                tb_monitor_inst.end_test(exp_frames[i], exp_errs[i], 2);
            end

            tb_monitor_inst.report_counts();
            if (tb_monitor_inst.total_errs == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

/* tb/link_test_stim.txt */
# name pkt_size pause_size frames injects rdy_random first_word(hex) exp_frames exp_errs
# frames run as one frame, idle, then the rest; rdy_random 1 gives random back-pressure
basic_frames 4 2 3 0 0 9de0763f 3 0
long_frames 16 5 2 0 0 9de0763f 2 0
min_sizes 2 1 5 0 0 9de0763f 5 0
backpressure 8 3 4 0 1 9de0763f 4 0
short_backpressure 3 1 6 0 1 9de0763f 6 0
inject_errors 12 2 3 4 0 9de0763f 3 4
single_inject 5 4 3 1 0 9de0763f 3 1
long_pause 6 9 3 0 1 9de0763f 3 0

/* files.f */
design/link_test_pkg.sv
design/sata_scrambler.sv
design/test_tx.sv
design/test_rx.sv
design/link_test_top.sv
tb/tb_monitor.sv
tb/tb_link_test.sv

/* Makefile */
# Verilator simulation of the link test loopback

VERILATOR ?= verilator
TOP       ?= tb_link_test
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
